// File: test/fpMulGolden.txt
# test  opA  opB  mode  expected result  expected flags (test in decimal, others in hex)
1 40400000 40400000 0 41100000 0
1 40400000 40400000 1 41100000 0
1 40400000 40400000 4 41100000 0
1 3FC00000 3F800000 2 3FC00000 0
1 C0000000 40400000 3 C0C00000 0
2 3F800001 3F800001 0 3F800002 0
2 3F800001 3F800001 3 3F800003 0
2 BF800001 3F800001 2 BF800003 0
2 3F800001 3FC00000 0 3FC00002 0
2 3F800001 3FC00000 1 3FC00001 0
2 3F800003 3FC00000 0 3FC00004 0
2 3F800003 3FC00000 4 3FC00005 0
2 BF800003 3FC00000 2 BFC00005 0
2 3FFFFFFE 3F800001 0 40000000 0
2 3FFFFFFE 3F800001 1 3FFFFFFF 0
3 00000000 40400000 0 00000000 0
3 80000000 40400000 0 80000000 0
3 00000001 C0400000 1 80000000 0
3 807FFFFF 807FFFFF 3 00000000 0
4 7F800000 C0000000 0 FF800000 0
4 FF800000 FF800000 2 7F800000 0
4 7F800000 00000000 0 7FC00000 0
4 7F800001 3F800000 0 7FC00000 0
4 FFC00000 00000001 3 7FC00000 0
5 7F000000 40000000 0 7F800000 2
5 7F000000 40000000 1 7F7FFFFF 2
5 FF000000 40000000 2 FF800000 2
5 FF000000 40000000 3 FF7FFFFF 2
5 7F7FFFFF 7F7FFFFF 4 7F800000 2
5 00800000 3F000000 0 00000000 1
5 80800000 00800000 1 80000000 1

// File: src.f
source/fpFormatPkg.sv
source/fpRoundPkg.sv
source/fpMulDecode.sv
source/fpMulBooth.sv
source/fpMulRound.sv
source/fpMulTop.sv
test/fpMul_props.sv
test/fpMulChecker.sv
test/fpMulTb.sv

// File: test/fpMulTb.sv
module fpMulTb
    import fpRoundPkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    logic                 clk;
    logic                 rstN;
    logic                 inValid;
    logic [31:0]          opA;
    logic [31:0]          opB;
    roundMode             mode;
    logic                 outValid;
    logic [31:0]          result;
    logic [flagWidth-1:0] flags;
    int                   errorCount;
    logic                 allDone;

    int          vecTest[$];
    logic [31:0] vecA[$];
    logic [31:0] vecB[$];
    logic [2:0]  vecMode[$];
    logic        loaded = 1'b0;
    logic [31:0] lfsr   = 32'h5ba143dc;

    fpMulTop UUT (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .opA      (opA),
        .opB      (opB),
        .mode     (mode),
        .outValid (outValid),
        .result   (result),
        .flags    (flags)
    );

    fpMulChecker scoreboard (
        .clk        (clk),
        .rstN       (rstN),
        .inValid    (inValid),
        .outValid   (outValid),
        .result     (result),
        .flags      (flags),
        .errorCount (errorCount),
        .allDone    (allDone)
    );

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        int          fd;
        string       line;
        int          t;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [3:0]  m;
        logic [3:0]  f;
        logic [1:0]  gap;
        rstN    = 1'b0;
        inValid = 1'b0;
        opA     = '0;
        opB     = '0;
        mode    = rndNearEven;
        fd = $fopen("test/fpMulGolden.txt", "r");
        if (fd == 0) begin
            $display("could not open test/fpMulGolden.txt");
            $display("Done: errors found");
            $finish;
        end else begin
            // skip the column description line
            void'($fgets(line, fd));
            while ($fscanf(fd, "%d %h %h %h %h %h", t, a, b, m, r, f) == 6) begin
                vecTest.push_back(t);
                vecA.push_back(a);
                vecB.push_back(b);
                vecMode.push_back(m[2:0]);
            end
            $fclose(fd);
            loaded = 1'b1;
            repeat (10) @(posedge clk);
            @(negedge clk);
            rstN = 1'b1;
            foreach (vecA[i]) begin
                // back-to-back for test 5
                if (vecTest[i] == 5) begin
                    gap = 2'd0;
                end else begin
                    lfsr   = lfsrStep(lfsr);
                    gap[0] = lfsr[0];
                    lfsr   = lfsrStep(lfsr);
                    gap[1] = lfsr[0];
                end
                repeat (gap) begin
                    @(negedge clk);
                    inValid = 1'b0;
                end
                @(negedge clk);
                inValid = 1'b1;
                opA     = vecA[i];
                opB     = vecB[i];
                mode    = roundMode'(vecMode[i]);
            end
            @(negedge clk);
            inValid = 1'b0;
            wait (allDone);
            @(negedge clk);
            if (errorCount == 0 && UUT.props.failCount == 0) begin
                $display("Done: no errors");
            end else begin
                $display("Done: errors found");
            end
            $finish;
        end
    end

    // five cycles per vector, reset, latency margin
    initial begin
        int limit;
        wait (loaded);
        limit = (vecA.size() * 5 + 10 + 20) * 20;
        #(limit);
        $display("run timed out after %0d ns without checking every vector", limit);
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: test/fpMulChecker.sv
module fpMulChecker
    import fpRoundPkg::*;
(
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 inValid,
    input  logic                 outValid,
    input  logic [31:0]          result,
    input  logic [flagWidth-1:0] flags,
    output int                   errorCount,
    output logic                 allDone
);
    timeunit 1ns;
    timeprecision 1ps;

    // edges from sampled input to sampled output
    localparam int latency = 3;

    int                   expTest[$];
    logic [31:0]          expResult[$];
    logic [flagWidth-1:0] expFlags[$];
    int                   issueEdge[$];
    int                   edgeCount    = 0;
    int                   checkedCount = 0;
    int                   testCount    = 0;
    int                   testVectors  = 0;
    int                   testErrors   = 0;

    initial begin
        int          fd;
        string       line;
        int          t;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [3:0]  m;
        logic [3:0]  f;
        errorCount = 0;
        allDone    = 1'b0;
        fd = $fopen("test/fpMulGolden.txt", "r");
        if (fd == 0) begin
            $display("checker could not open the golden file");
            errorCount = 1;
            allDone    = 1'b1;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line[0] != "#" &&
                    $sscanf(line, "%d %h %h %h %h %h", t, a, b, m, r, f) == 6) begin
                    expTest.push_back(t);
                    expResult.push_back(r);
                    expFlags.push_back(f[flagWidth-1:0]);
                end
            end
            $fclose(fd);
        end
    end

    // edge index of every accepted operation
    always @(posedge clk) begin
        edgeCount++;
        if (rstN && inValid) begin
            issueEdge.push_back(edgeCount);
        end
    end

    task automatic checkOne();
        int                   t;
        logic [31:0]          r;
        logic [flagWidth-1:0] f;
        int                   issued;
        int                   lag;
        t      = expTest.pop_front();
        r      = expResult.pop_front();
        f      = expFlags.pop_front();
        issued = (issueEdge.size() > 0) ? issueEdge.pop_front() : -1;
        // the coming rising edge is the one that samples this output
        lag    = edgeCount + 1 - issued;
        if (lag != latency) begin
            $display("output at %0d ns arrived %0d edges after its input instead of %0d",
                     $time, lag, latency);
            errorCount++;
            testErrors++;
        end
        if (result !== r) begin
            $display("error at %0d ns: result expected %h got %h", $time, r, result);
            errorCount++;
            testErrors++;
        end
        if (flags !== f) begin
            $display("error at %0d ns: flags expected %b got %b", $time, f, flags);
            errorCount++;
            testErrors++;
        end
        checkedCount++;
        testVectors++;
        // last vector of this test number
        if (expTest.size() == 0 || expTest[0] != t) begin
            $display("test %0d finished: %0d vectors, %0d errors", t, testVectors, testErrors);
            testCount++;
            testVectors = 0;
            testErrors  = 0;
        end
        if (expTest.size() == 0) begin
            $display("checked %0d vectors in %0d tests, %0d errors",
                     checkedCount, testCount, errorCount);
            allDone = 1'b1;
        end
    endtask

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (rstN && outValid) begin
            if (expResult.size() == 0) begin
                $display("output at %0d ns with no operation in flight", $time);
                errorCount++;
            end else begin
                checkOne();
            end
        end
    end

endmodule

// File: test/fpMul_props.sv
module fpMulProps
    import fpFormatPkg::*;
    import fpRoundPkg::*;
(
    input logic                 clk,
    input logic                 rstN,
    input logic                 inValid,
    input logic                 outValid,
    input logic [31:0]          result,
    input logic [flagWidth-1:0] flags
);
    timeunit 1ns;
    timeprecision 1ps;

    // assertion failures so far
    int failCount = 0;

    // nothing leaves the pipe while in reset
    resetQuiet: assert property (@(posedge clk) !rstN |-> !outValid)
        else begin
            failCount++;
            $error("outValid high during reset");
        end

    // fixed three-edge latency
    fixedLatency: assert property (@(posedge clk) disable iff (!rstN)
        inValid |-> ##3 outValid)
        else begin
            failCount++;
            $error("outValid missing three cycles after inValid");
        end

    // any NaN result must be the canonical one
    nanIsCanon: assert property (@(posedge clk) disable iff (!rstN)
        (outValid && result[30:23] == 8'hFF && result[22:0] != '0) |-> result == canonNaN)
        else begin
            failCount++;
            $error("non-canonical NaN result");
        end

    exclusiveFlags: assert property (@(posedge clk) disable iff (!rstN)
        outValid |-> !(flags[flagOvf] && flags[flagUnf]))
        else begin
            failCount++;
            $error("overflow and underflow both set");
        end

endmodule

bind fpMulTop fpMulProps props (
    .clk      (clk),
    .rstN     (rstN),
    .inValid  (inValid),
    .outValid (outValid),
    .result   (result),
    .flags    (flags)
);

// File: source/fpMulTop.sv
module fpMulTop
    import fpFormatPkg::*;
    import fpRoundPkg::*;
(
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 inValid,
    input  logic [31:0]          opA,
    input  logic [31:0]          opB,
    input  roundMode             mode,
    output logic                 outValid,
    output logic [31:0]          result,
    output logic [flagWidth-1:0] flags
);

    // decode to execute
    logic                       decValid;
    logic                       decSign;
    logic signed [sumWidth-1:0] decExpSum;
    logic [sigWidth-1:0]        decSigA;
    logic [sigWidth-1:0]        decSigB;
    opClass                     decClassA;
    opClass                     decClassB;
    roundMode                   decMode;

    // execute to result
    logic                       exeValid;
    logic [prodWidth-1:0]       exeProduct;
    logic                       exeSign;
    logic signed [sumWidth-1:0] exeExpSum;
    opClass                     exeClassA;
    opClass                     exeClassB;
    roundMode                   exeMode;

    fpMulDecode decode (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .opA      (opA),
        .opB      (opB),
        .mode     (mode),
        .decValid (decValid),
        .prodSign (decSign),
        .expSum   (decExpSum),
        .sigA     (decSigA),
        .sigB     (decSigB),
        .classA   (decClassA),
        .classB   (decClassB),
        .decMode  (decMode)
    );

    fpMulBooth execute (
        .clk         (clk),
        .rstN        (rstN),
        .inValid     (decValid),
        .sigA        (decSigA),
        .sigB        (decSigB),
        .prodSign    (decSign),
        .expSum      (decExpSum),
        .classA      (decClassA),
        .classB      (decClassB),
        .mode        (decMode),
        .exeValid    (exeValid),
        .product     (exeProduct),
        .prodSignOut (exeSign),
        .expSumOut   (exeExpSum),
        .classAOut   (exeClassA),
        .classBOut   (exeClassB),
        .modeOut     (exeMode)
    );

    fpMulRound resultStage (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (exeValid),
        .product  (exeProduct),
        .prodSign (exeSign),
        .expSum   (exeExpSum),
        .classA   (exeClassA),
        .classB   (exeClassB),
        .mode     (exeMode),
        .outValid (outValid),
        .result   (result),
        .flags    (flags)
    );

endmodule

// File: source/fpMulRound.sv
module fpMulRound
    import fpFormatPkg::*;
    import fpRoundPkg::*;
(
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       inValid,
    input  logic [prodWidth-1:0]       product,
    input  logic                       prodSign,
    input  logic signed [sumWidth-1:0] expSum,
    input  opClass                     classA,
    input  opClass                     classB,
    input  roundMode                   mode,
    output logic                       outValid,
    output logic [31:0]                result,
    output logic [flagWidth-1:0]       flags
);

    logic [prodWidth-1:0]       aligned;
    logic signed [sumWidth-1:0] expAdj;
    logic signed [sumWidth-1:0] expFinal;
    logic [normWidth-1:0]       normSig;
    logic                       lostBits;
    logic                       roundUp;
    logic [sigWidth:0]          rounded;
    logic                       overflow;
    logic                       underflow;
    logic                       ovfToInf;
    logic                       anyNaN;
    logic                       anyInf;
    logic                       anyZero;
    logic [31:0]                resultNext;
    logic [flagWidth-1:0]       flagsNext;

    // product of two normals lies in [1,4), so one place is enough
    assign aligned = product[prodWidth-1] ? product : {product[prodWidth-2:0], 1'b0};
    assign expAdj  = product[prodWidth-1] ? expSum + sumWidth'(1) : expSum;

    // top bits through round, rest collapsed into sticky
    assign normSig = {aligned[prodWidth-1 -: normWidth-1],
                      |aligned[prodWidth-normWidth:0]};

    assign lostBits = normSig[normGuard] | normSig[normRound] | normSig[normSticky];

    always_comb begin
        case (mode)
            rndNearEven:   roundUp = normSig[normGuard] &
                                     (normSig[normRound] | normSig[normSticky] |
                                      normSig[normLsb]);
            rndTowardZero: roundUp = 1'b0;
            rndDown:       roundUp = prodSign & lostBits;
            rndUp:         roundUp = !prodSign & lostBits;
            rndNearMax:    roundUp = normSig[normGuard];
            default:       roundUp = 1'b0;
        endcase
    end

    // on carry-out the fraction bits below are already all zero
    assign rounded  = {1'b0, normSig[normWidth-1:normLsb]} + (sigWidth + 1)'(roundUp);
    assign expFinal = rounded[sigWidth] ? expAdj + sumWidth'(1) : expAdj;

    assign overflow  = expFinal >= expMax;
    assign underflow = expFinal < 1;

    // directed modes saturate unless rounding points away from zero
    always_comb begin
        case (mode)
            rndTowardZero: ovfToInf = 1'b0;
            rndDown:       ovfToInf = prodSign;
            rndUp:         ovfToInf = !prodSign;
            default:       ovfToInf = 1'b1;
        endcase
    end

    assign anyNaN  = (classA == classNaN) || (classB == classNaN);
    assign anyInf  = (classA == classInf) || (classB == classInf);
    assign anyZero = (classA == classZero) || (classB == classZero);

    always_comb begin
        flagsNext = '0;
        if (anyNaN || (anyInf && anyZero)) begin
            resultNext = canonNaN;
        end else if (anyInf) begin
            resultNext = {prodSign, infMag};
        end else if (anyZero) begin
            resultNext = {prodSign, 31'b0};
        end else if (overflow) begin
            resultNext         = {prodSign, ovfToInf ? infMag : maxFiniteMag};
            flagsNext[flagOvf] = 1'b1;
        end else if (underflow) begin
            // flush to signed zero
            resultNext         = {prodSign, 31'b0};
            flagsNext[flagUnf] = 1'b1;
        end else begin
            resultNext = {prodSign, expFinal[expWidth-1:0], rounded[fracWidth-1:0]};
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outValid <= 1'b0;
            result   <= '0;
            flags    <= '0;
        end else begin
            outValid <= inValid;
            if (inValid) begin
                result <= resultNext;
                flags  <= flagsNext;
            end
        end
    end

endmodule

// File: source/fpMulBooth.sv
module fpMulBooth
    import fpFormatPkg::*;
    import fpRoundPkg::*;
(
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       inValid,
    input  logic [sigWidth-1:0]        sigA,
    input  logic [sigWidth-1:0]        sigB,
    input  logic                       prodSign,
    input  logic signed [sumWidth-1:0] expSum,
    input  opClass                     classA,
    input  opClass                     classB,
    input  roundMode                   mode,
    output logic                       exeValid,
    output logic [prodWidth-1:0]       product,
    output logic                       prodSignOut,
    output logic signed [sumWidth-1:0] expSumOut,
    output opClass                     classAOut,
    output opClass                     classBOut,
    output roundMode                   modeOut
);

    // multiplier zero-extended to an even width, plus the implicit bit below lsb
    logic [2*boothDigits:0] bExt;

    // partial products span -2A .. +2A
    logic signed [sigWidth+1:0] sigOnce;
    logic signed [sigWidth+1:0] sigTwice;
    logic signed [sigWidth+1:0] partial [boothDigits];

    logic [prodWidth-1:0] sum;
    logic                 zeroOp;

    assign bExt     = {{(2 * boothDigits - sigWidth){1'b0}}, sigB, 1'b0};
    assign sigOnce  = {2'b00, sigA};
    assign sigTwice = {1'b0, sigA, 1'b0};

    // one booth digit per overlapping bit triplet
    always_comb begin
        for (int i = 0; i < boothDigits; i++) begin
            case (bExt[2*i+2 -: 3])
                3'b001, 3'b010: partial[i] = sigOnce;
                3'b011:         partial[i] = sigTwice;
                3'b100:         partial[i] = -sigTwice;
                3'b101, 3'b110: partial[i] = -sigOnce;
                default:        partial[i] = '0;
            endcase
        end
    end

    // sign-extended sum, wraps to the exact product modulo 2^48
    always_comb begin
        sum = '0;
        for (int i = 0; i < boothDigits; i++) begin
            sum = sum + (prodWidth'(partial[i]) << (2 * i));
        end
    end

    // a flushed operand forces a clean zero product
    assign zeroOp = (classA == classZero) || (classB == classZero);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exeValid <= 1'b0;
        end else begin
            exeValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid) begin
            product     <= zeroOp ? '0 : sum;
            prodSignOut <= prodSign;
            expSumOut   <= expSum;
            classAOut   <= classA;
            classBOut   <= classB;
            modeOut     <= mode;
        end
    end

endmodule

// File: source/fpMulDecode.sv
module fpMulDecode
    import fpFormatPkg::*;
    import fpRoundPkg::*;
(
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       inValid,
    input  logic [31:0]                opA,
    input  logic [31:0]                opB,
    input  roundMode                   mode,
    output logic                       decValid,
    output logic                       prodSign,
    output logic signed [sumWidth-1:0] expSum,
    output logic [sigWidth-1:0]        sigA,
    output logic [sigWidth-1:0]        sigB,
    output opClass                     classA,
    output opClass                     classB,
    output roundMode                   decMode
);

    logic [expWidth-1:0]        expA;
    logic [expWidth-1:0]        expB;
    logic signed [sumWidth-1:0] expSumNext;

    // zero exponent means zero or subnormal, both flushed
    function automatic opClass classify(input logic [31:0] op);
        logic [expWidth-1:0] e;
        e = op[expMsb:expLsb];
        if (e == '0) begin
            return classZero;
        end
        if (e == expWidth'(expMax)) begin
            if (op[fracMsb:0] == '0) begin
                return classInf;
            end
            return classNaN;
        end
        return classNormal;
    endfunction

    assign expA = opA[expMsb:expLsb];
    assign expB = opB[expMsb:expLsb];

    // rebias so the sum carries a single bias
    assign expSumNext = $signed({2'b00, expA}) + $signed({2'b00, expB})
                      - sumWidth'(expBias);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            decValid <= 1'b0;
        end else begin
            decValid <= inValid;
        end
    end

    // payload follows the strobe
    always_ff @(posedge clk) begin
        if (inValid) begin
            prodSign <= opA[signPos] ^ opB[signPos];
            expSum   <= expSumNext;
            sigA     <= {1'b1, opA[fracMsb:0]};
            sigB     <= {1'b1, opB[fracMsb:0]};
            classA   <= classify(opA);
            classB   <= classify(opB);
            decMode  <= mode;
        end
    end

endmodule

// File: source/fpRoundPkg.sv
package fpRoundPkg;

    // codes match the external mode input
    typedef enum logic [2:0] {
        rndNearEven   = 3'b000,
        rndTowardZero = 3'b001,
        rndDown       = 3'b010,
        rndUp         = 3'b011,
        rndNearMax    = 3'b100
    } roundMode;

    // hidden one, 23 fraction bits, guard, round, sticky
    localparam int normWidth  = 27;
    localparam int normLsb    = 3;
    localparam int normGuard  = 2;
    localparam int normRound  = 1;
    localparam int normSticky = 0;

    // flag bit positions
    localparam int flagWidth = 2;
    localparam int flagOvf   = 1;
    localparam int flagUnf   = 0;

endpackage

// File: source/fpFormatPkg.sv
package fpFormatPkg;

    // binary32 field widths
    localparam int expWidth  = 8;
    localparam int fracWidth = 23;

    // field positions inside the 32-bit word
    localparam int signPos = 31;
    localparam int expMsb  = 30;
    localparam int expLsb  = 23;
    localparam int fracMsb = 22;

    // exponent encoding
    localparam int expBias = 127;
    localparam int expMax  = 255;

    // biased exponent sum needs two extra bits and a sign
    localparam int sumWidth = expWidth + 2;

    // significand with hidden one, and the full product
    localparam int sigWidth  = fracWidth + 1;
    localparam int prodWidth = 2 * sigWidth;

    // radix-4 digits over the zero-extended multiplier
    localparam int boothDigits = (sigWidth + 2) / 2;

    // special encodings, magnitude only unless noted
    localparam logic [31:0] canonNaN     = 32'h7FC0_0000;
    localparam logic [30:0] infMag       = 31'h7F80_0000;
    localparam logic [30:0] maxFiniteMag = 31'h7F7F_FFFF;

    // subnormals fold into classZero
    typedef enum logic [1:0] {
        classZero   = 2'b00,
        classNormal = 2'b01,
        classInf    = 2'b10,
        classNaN    = 2'b11
    } opClass;

endpackage
